/* trdb_cpu_pkg.sv */
package trdb_cpu_pkg;

    // datapath widths of the core retirement interface
    localparam int unsigned XLEN    = 32;
    localparam int unsigned CAUSE_W = 5;
    localparam int unsigned PRIV_W  = 2;

    // major opcodes that matter to the trace decision
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct12 field of the trap return instructions
    localparam logic [11:0] F12_MRET = 12'h302;
    localparam logic [11:0] F12_SRET = 12'h102;

    // instruction class seen by the encoder
    // updiscon: target cannot be inferred from the binary (jalr, mret, sret)
    typedef enum logic [1:0] {
        IC_OTHER    = 2'd0,
        IC_BRANCH   = 2'd1,
        IC_UPDISCON = 2'd2
    } instr_class_e;

    // one retirement as it moves through nc, tc and lc
    typedef struct packed {
        logic                qualified;
        logic                exception;
        logic                interrupt;
        logic [CAUSE_W-1:0]  cause;
        logic [XLEN-1:0]     tval;
        logic [PRIV_W-1:0]   priv;
        logic [XLEN-1:0]     pc;
        instr_class_e        iclass;
    } retire_t;

endpackage

/* trdb_pkg.sv */
package trdb_pkg;

    // branch map limits
    localparam int unsigned BMAP_DEPTH = 31;
    localparam int unsigned BMAP_CNT_W = 5;

    // packet output widths
    localparam int unsigned PAYLOAD_W = 96;
    localparam int unsigned PTYPE_W   = 4;
    localparam int unsigned PLEN_W    = 4;

    // e-trace packet formats, format 0 is not generated
    typedef enum logic [1:0] {
        F1_BRANCH_ADDR = 2'd1,
        F2_ADDR        = 2'd2,
        F3_SYNC        = 2'd3
    } packet_format_e;

    // format 3 subformats
    typedef enum logic [1:0] {
        SF_START     = 2'd0,
        SF_EXCEPTION = 2'd1
    } sync_subformat_e;

    // packet type as driven on packet_type_o, subformat in the upper half
    typedef struct packed {
        sync_subformat_e subformat;
        packet_format_e  format;
    } ptype_t;

    // payload layouts, msb first, zero extended to PAYLOAD_W on the output
    typedef struct packed {
        logic [BMAP_CNT_W-1:0]       branches;
        logic [BMAP_DEPTH-1:0]       branch_map;
        logic [trdb_cpu_pkg::XLEN-1:0] address;
    } f1_payload_t;

    typedef struct packed {
        logic [trdb_cpu_pkg::XLEN-1:0] address;
    } f2_payload_t;

    typedef struct packed {
        logic [trdb_cpu_pkg::PRIV_W-1:0] priv;
        logic [trdb_cpu_pkg::XLEN-1:0]   address;
    } f3_start_payload_t;

    typedef struct packed {
        logic [trdb_cpu_pkg::CAUSE_W-1:0] cause;
        logic                             interrupt;
        logic [trdb_cpu_pkg::PRIV_W-1:0]  priv;
        logic [trdb_cpu_pkg::XLEN-1:0]    tval;
        logic [trdb_cpu_pkg::XLEN-1:0]    address;
    } f3_exc_payload_t;

    // packet lengths in bytes
    localparam logic [PLEN_W-1:0] PLEN_F1       = 4'd9;
    localparam logic [PLEN_W-1:0] PLEN_F1_FULL  = 4'd5;
    localparam logic [PLEN_W-1:0] PLEN_F2       = 4'd5;
    localparam logic [PLEN_W-1:0] PLEN_F3_START = 4'd5;
    localparam logic [PLEN_W-1:0] PLEN_F3_EXC   = 4'd10;

    // length lookup, a branch count of 0 in format 1 means full map without address
    function automatic logic [PLEN_W-1:0] packet_length(input packet_format_e fmt,
            input sync_subformat_e subformat, input logic [BMAP_CNT_W-1:0] branches);
        logic [PLEN_W-1:0] len;
        case (fmt)
            F1_BRANCH_ADDR: len = (branches == '0) ? PLEN_F1_FULL : PLEN_F1;
            F2_ADDR:        len = PLEN_F2;
            F3_SYNC:        len = (subformat == SF_EXCEPTION) ? PLEN_F3_EXC : PLEN_F3_START;
            default:        len = '0;
        endcase
        return len;
    endfunction

endpackage

/* trdb_trigger_filter.sv */
`timescale 1ns/100ps

module trdb_trigger_filter import trdb_cpu_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                iretired_i,
    input  logic                exception_i,
    input  logic                interrupt_i,
    input  logic [CAUSE_W-1:0]  cause_i,
    input  logic [XLEN-1:0]     tval_i,
    input  logic [PRIV_W-1:0]   priv_lvl_i,
    input  logic [XLEN-1:0]     inst_data_i,
    input  logic [XLEN-1:0]     pc_i,
    input  logic [3:0]          trigger_i,
    output retire_t             ret_o
);

    // trigger codes from the debug module
    localparam logic [3:0] TRIG_TRACE_ON  = 4'd2;
    localparam logic [3:0] TRIG_TRACE_OFF = 4'd3;

    typedef enum logic {
        TRACE_OFF = 1'b0,
        TRACE_ON  = 1'b1
    } trace_state_e;

    trace_state_e trace_state_q;
    trace_state_e trace_state_d;
    opcode_e      opcode;
    instr_class_e iclass;

    // next enable state, also used by the retirement of this cycle
    always_comb begin
        trace_state_d = trace_state_q;
        if (trigger_i == TRIG_TRACE_ON) begin
            trace_state_d = TRACE_ON;
        end else if (trigger_i == TRIG_TRACE_OFF) begin
            trace_state_d = TRACE_OFF;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trace_state_q <= TRACE_OFF;
        end else begin
            trace_state_q <= trace_state_d;
        end
    end

    // decode the class from opcode, funct3 and funct12
    assign opcode = opcode_e'(inst_data_i[6:0]);

    always_comb begin
        iclass = IC_OTHER;
        case (opcode)
            OPC_BRANCH: iclass = IC_BRANCH;
            OPC_JALR:   iclass = IC_UPDISCON;
            OPC_SYSTEM: begin
                // trap returns only, ecall and csr ops stay inferable
                if ((inst_data_i[14:12] == 3'b000) &&
                    ((inst_data_i[31:20] == F12_MRET) || (inst_data_i[31:20] == F12_SRET))) begin
                    iclass = IC_UPDISCON;
                end
            end
            default: iclass = IC_OTHER;
        endcase
    end

    assign ret_o = '{
        qualified: iretired_i && (trace_state_d == TRACE_ON),
        exception: exception_i,
        interrupt: interrupt_i,
        cause:     cause_i,
        tval:      tval_i,
        priv:      priv_lvl_i,
        pc:        pc_i,
        iclass:    iclass
    };

endmodule

/* trdb_stage_pipe.sv */
`timescale 1ns/100ps

module trdb_stage_pipe import trdb_cpu_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  retire_t ret_i,
    output retire_t tc_ret_o,
    output retire_t nc_ret_o,
    output logic    lc_exception_o,
    output logic    lc_updiscon_o,
    output logic    tc_first_qualified_o,
    output logic    tc_branch_taken_o
);

    // three stage shift, nc is the newest entry
    retire_t nc_q;
    retire_t tc_q;
    retire_t lc_q;
    logic [XLEN-1:0] tc_seq_pc;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            nc_q <= '0;
            tc_q <= '0;
            lc_q <= '0;
        end else begin
            nc_q <= ret_i;
            tc_q <= nc_q;
            lc_q <= tc_q;
        end
    end

    assign tc_ret_o = tc_q;
    assign nc_ret_o = nc_q;

    // last cycle flags only count for a traced entry
    assign lc_exception_o = lc_q.qualified && lc_q.exception;
    assign lc_updiscon_o  = lc_q.qualified && (lc_q.iclass == IC_UPDISCON);

    // start of a traced run
    assign tc_first_qualified_o = tc_q.qualified && !lc_q.qualified;

    // no compressed instructions, so fall-through is always pc + 4
    assign tc_seq_pc = tc_q.pc + XLEN'(4);

    // taken when the next traced pc is not the fall-through address
    // a branch ahead of a gap is seen as not taken
    assign tc_branch_taken_o = nc_q.qualified && (nc_q.pc != tc_seq_pc);

endmodule

/* trdb_branch_map.sv */
`timescale 1ns/100ps

module trdb_branch_map import trdb_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  tc_is_branch_i,
    input  logic                  tc_taken_i,
    input  logic                  flush_i,
    output logic [BMAP_CNT_W-1:0] bmap_count_o,
    output logic [BMAP_DEPTH-1:0] bmap_bits_o,
    output logic                  bmap_full_o
);

    logic [BMAP_CNT_W-1:0] count_q;
    logic [BMAP_DEPTH-1:0] bits_q;

    // map contents as seen after a possible flush
    logic [BMAP_CNT_W-1:0] base_count;
    logic [BMAP_DEPTH-1:0] base_bits;

    assign base_count = flush_i ? '0 : count_q;
    assign base_bits  = flush_i ? '0 : bits_q;

    // a branch in the flushing cycle lands in the fresh map
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
            bits_q  <= '0;
        end else if (tc_is_branch_i) begin
            count_q <= base_count + 1'b1;
            // newest outcome in bit 0
            bits_q  <= {base_bits[BMAP_DEPTH-2:0], tc_taken_i};
        end else begin
            count_q <= base_count;
            bits_q  <= base_bits;
        end
    end

    assign bmap_count_o = count_q;
    assign bmap_bits_o  = bits_q;

    // full map must leave in the next packet
    assign bmap_full_o = (count_q == BMAP_CNT_W'(BMAP_DEPTH));

endmodule

/* trdb_packet_emitter.sv */
`timescale 1ns/100ps

module trdb_packet_emitter import trdb_cpu_pkg::*, trdb_pkg::*; #(
    parameter int unsigned MAX_RESYNC = 64
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  retire_t               tc_ret_i,
    input  retire_t               nc_ret_i,
    input  logic                  lc_exception_i,
    input  logic                  lc_updiscon_i,
    input  logic                  tc_first_qualified_i,
    input  logic [BMAP_CNT_W-1:0] bmap_count_i,
    input  logic [BMAP_DEPTH-1:0] bmap_bits_i,
    input  logic                  bmap_full_i,
    output logic                  flush_o,
    output logic                  packet_valid_o,
    output logic [PTYPE_W-1:0]    packet_type_o,
    output logic [PLEN_W-1:0]     packet_length_o,
    output logic [PAYLOAD_W-1:0]  packet_payload_o
);

    localparam int unsigned RESYNC_W = $clog2(MAX_RESYNC + 1);

    logic [RESYNC_W-1:0]   resync_cnt_q;
    logic                  resync_due;
    // tc fields one cycle later, i.e. the lc entry
    retire_t               lc_hold_q;

    logic                  emit;
    logic                  sync_clr;
    ptype_t                ptype;
    logic [BMAP_CNT_W-1:0] f1_count;
    logic [PAYLOAD_W-1:0]  payload_d;

    // address packet shared by updiscon and final instruction
    f1_payload_t           f1_addr;
    f1_payload_t           f1_full;
    f2_payload_t           f2_addr;
    f3_start_payload_t     f3_start;
    f3_exc_payload_t       f3_exc;
    logic                  addr_has_map;

    assign resync_due   = (resync_cnt_q >= RESYNC_W'(MAX_RESYNC - 1));
    assign addr_has_map = (bmap_count_i != '0);

    assign f1_addr  = '{branches: bmap_count_i, branch_map: bmap_bits_i, address: tc_ret_i.pc};
    // full map goes out with count 0 and no address
    assign f1_full  = '{branches: '0, branch_map: bmap_bits_i, address: '0};
    assign f2_addr  = '{address: tc_ret_i.pc};
    assign f3_start = '{priv: tc_ret_i.priv, address: tc_ret_i.pc};
    // handler address is the pc that follows the trap
    assign f3_exc   = '{cause: lc_hold_q.cause, interrupt: lc_hold_q.interrupt,
                        priv: lc_hold_q.priv, tval: lc_hold_q.tval, address: tc_ret_i.pc};

    // priority decision, first match wins
    always_comb begin
        emit      = 1'b0;
        sync_clr  = 1'b0;
        ptype     = '{subformat: SF_START, format: F2_ADDR};
        f1_count  = bmap_count_i;
        payload_d = '0;
        if (tc_ret_i.qualified) begin
            emit = 1'b1;
            if (tc_first_qualified_i || (!lc_exception_i && !lc_updiscon_i && resync_due)) begin
                // start of trace or periodic resync
                sync_clr  = 1'b1;
                ptype     = '{subformat: SF_START, format: F3_SYNC};
                payload_d = PAYLOAD_W'(f3_start);
            end else if (lc_exception_i) begin
                ptype     = '{subformat: SF_EXCEPTION, format: F3_SYNC};
                payload_d = PAYLOAD_W'(f3_exc);
            end else if (bmap_full_i && !lc_updiscon_i) begin
                ptype     = '{subformat: SF_START, format: F1_BRANCH_ADDR};
                f1_count  = '0;
                payload_d = PAYLOAD_W'(f1_full);
            end else if (lc_updiscon_i || !nc_ret_i.qualified) begin
                // uninferable jump or last traced instruction
                if (addr_has_map) begin
                    ptype     = '{subformat: SF_START, format: F1_BRANCH_ADDR};
                    payload_d = PAYLOAD_W'(f1_addr);
                end else begin
                    payload_d = PAYLOAD_W'(f2_addr);
                end
            end else begin
                emit = 1'b0;
            end
        end
    end

    // every packet restarts the branch map
    assign flush_o = emit;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resync_cnt_q   <= '0;
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= emit;
            if (sync_clr) begin
                resync_cnt_q <= '0;
            end else if (tc_ret_i.qualified && !resync_due) begin
                // saturates one below the limit until a sync goes out
                resync_cnt_q <= resync_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        lc_hold_q <= tc_ret_i;
        if (emit) begin
            packet_type_o    <= ptype;
            packet_length_o  <= packet_length(ptype.format, ptype.subformat, f1_count);
            packet_payload_o <= payload_d;
        end
    end

endmodule

/* trace_debugger.sv */
`timescale 1ns/100ps

module trace_debugger import trdb_cpu_pkg::*, trdb_pkg::*; #(
    parameter int unsigned MAX_RESYNC = 64
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // retirement interface of the core
    input  logic                 iretired_i,
    input  logic                 exception_i,
    input  logic                 interrupt_i,
    input  logic [CAUSE_W-1:0]   cause_i,
    input  logic [XLEN-1:0]      tval_i,
    input  logic [PRIV_W-1:0]    priv_lvl_i,
    input  logic [XLEN-1:0]      inst_data_i,
    input  logic [XLEN-1:0]      pc_i,
    input  logic [3:0]           trigger_i,
    // packet strobe towards the encapsulator
    output logic                 packet_valid_o,
    output logic [PTYPE_W-1:0]   packet_type_o,
    output logic [PLEN_W-1:0]    packet_length_o,
    output logic [PAYLOAD_W-1:0] packet_payload_o
);

    retire_t               ret_in;
    retire_t               tc_ret;
    retire_t               nc_ret;
    logic                  lc_exception;
    logic                  lc_updiscon;
    logic                  tc_first_qualified;
    logic                  tc_branch_taken;
    logic [BMAP_CNT_W-1:0] bmap_count;
    logic [BMAP_DEPTH-1:0] bmap_bits;
    logic                  bmap_full;
    logic                  flush;

    // qualify and classify the retirement
    trdb_trigger_filter u_trigger_filter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .iretired_i  (iretired_i),
        .exception_i (exception_i),
        .interrupt_i (interrupt_i),
        .cause_i     (cause_i),
        .tval_i      (tval_i),
        .priv_lvl_i  (priv_lvl_i),
        .inst_data_i (inst_data_i),
        .pc_i        (pc_i),
        .trigger_i   (trigger_i),
        .ret_o       (ret_in)
    );

    // nc, tc and lc stages
    trdb_stage_pipe u_stage_pipe (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .ret_i                (ret_in),
        .tc_ret_o             (tc_ret),
        .nc_ret_o             (nc_ret),
        .lc_exception_o       (lc_exception),
        .lc_updiscon_o        (lc_updiscon),
        .tc_first_qualified_o (tc_first_qualified),
        .tc_branch_taken_o    (tc_branch_taken)
    );

    trdb_branch_map u_branch_map (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .tc_is_branch_i (tc_ret.qualified && (tc_ret.iclass == IC_BRANCH)),
        .tc_taken_i     (tc_branch_taken),
        .flush_i        (flush),
        .bmap_count_o   (bmap_count),
        .bmap_bits_o    (bmap_bits),
        .bmap_full_o    (bmap_full)
    );

    trdb_packet_emitter #(
        .MAX_RESYNC (MAX_RESYNC)
    ) u_packet_emitter (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .tc_ret_i             (tc_ret),
        .nc_ret_i             (nc_ret),
        .lc_exception_i       (lc_exception),
        .lc_updiscon_i        (lc_updiscon),
        .tc_first_qualified_i (tc_first_qualified),
        .bmap_count_i         (bmap_count),
        .bmap_bits_i          (bmap_bits),
        .bmap_full_i          (bmap_full),
        .flush_o              (flush),
        .packet_valid_o       (packet_valid_o),
        .packet_type_o        (packet_type_o),
        .packet_length_o      (packet_length_o),
        .packet_payload_o     (packet_payload_o)
    );

endmodule

/* trdb_checker.sv */
`timescale 1ns/100ps

module trdb_checker (
    input logic        clk_i,
    input logic        reset_i,
    input logic        iretired_i,
    input logic [3:0]  trigger_i,
    input logic        packet_valid_i,
    input logic [3:0]  packet_type_i,
    input logic [3:0]  packet_length_i,
    input logic [95:0] packet_payload_i
);

    // trace enable as seen from the trigger codes alone
    logic trace_on_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trace_on_q <= 1'b0;
        end else if (trigger_i == 4'd2) begin
            trace_on_q <= 1'b1;
        end else if (trigger_i == 4'd3) begin
            trace_on_q <= 1'b0;
        end
    end

    // byte length expected for a packet type
    // format 1 with branch count 0 is the full map without address
    function automatic logic [3:0] table_length(input logic [3:0] ptype,
            input logic [4:0] branches);
        logic [3:0] len;
        case (ptype)
            4'h1:    len = (branches == 5'd0) ? 4'd5 : 4'd9;
            4'h2:    len = 4'd5;
            4'h3:    len = 4'd5;
            4'h7:    len = 4'd10;
            default: len = 4'd0;
        endcase
        return len;
    endfunction

    // strobe stays low in reset and in the first cycle out of it
    valid_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !packet_valid_i)
        else $error("packet strobe active during reset or in the cycle after it");

    // branch count sits at payload bits 67:63 for format 1
    length_matches_type: assert property (@(posedge clk_i) disable iff (reset_i)
        packet_valid_i |-> (packet_length_i == table_length(packet_type_i,
                                                            packet_payload_i[67:63])))
        else $error("packet length does not match the packet type");

    // a retirement with tracing off and no trace-on trigger gives no packet
    // when it would leave the pipe
    no_packet_untraced: assert property (@(posedge clk_i) disable iff (reset_i)
        (iretired_i && !trace_on_q && (trigger_i != 4'd2)) |-> ##3 !packet_valid_i)
        else $error("packet emitted for a retirement while tracing was off");

endmodule

bind trace_debugger trdb_checker u_checker (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .iretired_i       (iretired_i),
    .trigger_i        (trigger_i),
    .packet_valid_i   (packet_valid_o),
    .packet_type_i    (packet_type_o),
    .packet_length_i  (packet_length_o),
    .packet_payload_i (packet_payload_o)
);

/* trdb_tb.sv */
`timescale 1ns/100ps

module trdb_tb;

    localparam int unsigned MAX_RESYNC = 16;
    localparam logic [31:0] SEED       = 32'hcbe45a5a;

    // cycle budget per test phase
    localparam int unsigned RESET_CYCLES  = 4;
    localparam int unsigned IDLE_CYCLES   = 20;
    localparam int unsigned START_CYCLES  = 20;
    localparam int unsigned EXC_CYCLES    = 80;
    localparam int unsigned BMAP_CYCLES   = 160;
    localparam int unsigned RESYNC_CYCLES = 40;
    localparam int unsigned RANDOM_CYCLES = 1666;
    localparam int unsigned DRAIN_CYCLES  = 10;
    localparam int unsigned TIMEOUT_CYCLES = 2 * (RESET_CYCLES + IDLE_CYCLES + START_CYCLES +
        EXC_CYCLES + BMAP_CYCLES + RESYNC_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES);

    // instruction words used by the generator
    localparam logic [31:0] INSN_ADDI  = 32'h00000013;
    localparam logic [31:0] INSN_BEQ   = 32'h00208463;
    localparam logic [31:0] INSN_JALR  = 32'h00008067;
    localparam logic [31:0] INSN_MRET  = 32'h30200073;
    localparam logic [31:0] INSN_SRET  = 32'h10200073;
    localparam logic [31:0] INSN_ECALL = 32'h00000073;

    // one cycle of core signals, branch and jump are generator tags only
    typedef struct packed {
        logic        iret;
        logic        exc;
        logic        intr;
        logic [4:0]  cause;
        logic [31:0] tval;
        logic [1:0]  priv;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [3:0]  trig;
        logic        branch;
        logic        jump;
    } stim_t;

    // model view of one stage
    typedef struct packed {
        logic        q;
        logic        exc;
        logic        intr;
        logic [4:0]  cause;
        logic [31:0] tval;
        logic [1:0]  priv;
        logic [31:0] pc;
        logic        branch;
        logic        jump;
    } stage_t;

    typedef struct packed {
        logic        valid;
        logic [3:0]  ptype;
        logic [3:0]  len;
        logic [95:0] payload;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        iretired;
    logic        exception;
    logic        interrupt;
    logic [4:0]  cause;
    logic [31:0] tval;
    logic [1:0]  priv_lvl;
    logic [31:0] inst_data;
    logic [31:0] pc;
    logic [3:0]  trigger;
    logic        packet_valid;
    logic [3:0]  packet_type;
    logic [3:0]  packet_length;
    logic [95:0] packet_payload;

    // reference model state after the last rising edge
    logic        trace_on;
    stage_t      nc;
    stage_t      tc;
    stage_t      lc;
    logic [4:0]  map_cnt;
    logic [30:0] map_bits;
    int unsigned sync_cnt;
    expect_t     expect_q[$];
    logic [31:0] cur_pc;
    logic [1:0]  cur_priv;
    int unsigned cycle_count;

    trace_debugger #(
        .MAX_RESYNC (MAX_RESYNC)
    ) DUT (
        .clk_i            (clk),
        .reset_i          (reset),
        .iretired_i       (iretired),
        .exception_i      (exception),
        .interrupt_i      (interrupt),
        .cause_i          (cause),
        .tval_i           (tval),
        .priv_lvl_i       (priv_lvl),
        .inst_data_i      (inst_data),
        .pc_i             (pc),
        .trigger_i        (trigger),
        .packet_valid_o   (packet_valid),
        .packet_type_o    (packet_type),
        .packet_length_o  (packet_length),
        .packet_payload_o (packet_payload)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [95:0] exp_val,
            input logic [95:0] act_val);
        fail_run($sformatf("[ERROR] %0t ns %s expected %0h actual %0h",
                           $time, name, exp_val, act_val));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
        end
    end

    // packet the model expects for the entry now in tc
    function automatic expect_t model_packet();
        expect_t e;
        logic    lc_exc;
        logic    lc_jump;
        logic    resync;
        e       = '0;
        lc_exc  = lc.q && lc.exc;
        lc_jump = lc.q && lc.jump;
        resync  = (sync_cnt >= MAX_RESYNC - 1);
        if (tc.q) begin
            e.valid = 1'b1;
            if (!lc.q || (resync && !lc_exc && !lc_jump)) begin
                // start of trace or periodic sync
                e.ptype   = 4'h3;
                e.len     = 4'd5;
                e.payload = {62'd0, tc.priv, tc.pc};
            end else if (lc_exc) begin
                // handler address is the pc that follows the trap
                e.ptype   = 4'h7;
                e.len     = 4'd10;
                e.payload = {24'd0, lc.cause, lc.intr, lc.priv, lc.tval, tc.pc};
            end else if ((map_cnt == 5'd31) && !lc_jump) begin
                e.ptype   = 4'h1;
                e.len     = 4'd5;
                e.payload = {28'd0, 5'd0, map_bits, 32'd0};
            end else if (lc_jump || !nc.q) begin
                if (map_cnt != 5'd0) begin
                    e.ptype   = 4'h1;
                    e.len     = 4'd9;
                    e.payload = {28'd0, map_cnt, map_bits, tc.pc};
                end else begin
                    e.ptype   = 4'h2;
                    e.len     = 4'd5;
                    e.payload = {64'd0, tc.pc};
                end
            end else begin
                e.valid = 1'b0;
            end
        end
        return e;
    endfunction

    // advance the model across one rising edge
    task automatic model_step(input stim_t s, input expect_t e);
        logic        taken;
        logic [4:0]  cnt;
        logic [30:0] bits;
        // a branch is taken when the next traced pc is not the fall-through
        taken = nc.q && (nc.pc != tc.pc + 32'd4);
        cnt   = e.valid ? 5'd0 : map_cnt;
        bits  = e.valid ? 31'd0 : map_bits;
        if (tc.q && tc.branch) begin
            cnt  = cnt + 5'd1;
            bits = {bits[29:0], taken};
        end
        map_cnt  = cnt;
        map_bits = bits;
        if (e.valid && (e.ptype == 4'h3)) begin
            sync_cnt = 0;
        end else if (tc.q && (sync_cnt < MAX_RESYNC - 1)) begin
            sync_cnt++;
        end
        // trigger counts for the retirement of the same cycle
        if (s.trig == 4'd2) begin
            trace_on = 1'b1;
        end else if (s.trig == 4'd3) begin
            trace_on = 1'b0;
        end
        lc = tc;
        tc = nc;
        nc = '{q: s.iret && trace_on, exc: s.exc, intr: s.intr, cause: s.cause,
               tval: s.tval, priv: s.priv, pc: s.pc, branch: s.branch, jump: s.jump};
    endtask

    task automatic check_outputs(input expect_t e);
        assert (packet_valid === e.valid)
            else report_mismatch("packet_valid_o", 96'(e.valid), 96'(packet_valid));
        if (e.valid) begin
            assert (packet_type === e.ptype)
                else report_mismatch("packet_type_o", 96'(e.ptype), 96'(packet_type));
            assert (packet_length === e.len)
                else report_mismatch("packet_length_o", 96'(e.len), 96'(packet_length));
            assert (packet_payload === e.payload)
                else report_mismatch("packet_payload_o", e.payload, packet_payload);
        end
    endtask

    // outputs of the last edge are checked, then the next inputs go out
    task automatic drive_cycle(input stim_t s);
        expect_t e;
        @(negedge clk);
        if (expect_q.size() > 0) begin
            check_outputs(expect_q.pop_front());
        end
        e = model_packet();
        expect_q.push_back(e);
        iretired  = s.iret;
        exception = s.exc;
        interrupt = s.intr;
        cause     = s.cause;
        tval      = s.tval;
        priv_lvl  = s.priv;
        inst_data = s.inst;
        pc        = s.pc;
        trigger   = s.trig;
        model_step(s, e);
    endtask

    function automatic stim_t make_stim(input logic [31:0] inst, input logic [3:0] trig);
        stim_t s;
        s      = '0;
        s.iret = 1'b1;
        s.priv = cur_priv;
        s.inst = inst;
        s.pc   = cur_pc;
        s.trig = trig;
        return s;
    endfunction

    task automatic idle_cycle(input logic [3:0] trig);
        stim_t s;
        s      = '0;
        s.priv = cur_priv;
        s.inst = INSN_ADDI;
        s.trig = trig;
        drive_cycle(s);
    endtask

    task automatic retire_seq(input logic [3:0] trig);
        drive_cycle(make_stim(INSN_ADDI, trig));
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic retire_branch(input logic taken);
        stim_t s;
        s        = make_stim(INSN_BEQ, 4'd0);
        s.branch = 1'b1;
        drive_cycle(s);
        // taken offset is never 4
        cur_pc = taken ? cur_pc + 32'd8 + 32'(4 * ($urandom % 32)) : cur_pc + 32'd4;
    endtask

    task automatic retire_jump();
        stim_t s;
        case ($urandom % 3)
            0:       s = make_stim(INSN_JALR, 4'd0);
            1:       s = make_stim(INSN_MRET, 4'd0);
            default: s = make_stim(INSN_SRET, 4'd0);
        endcase
        s.jump = 1'b1;
        drive_cycle(s);
        cur_pc = $urandom & 32'hffff_fffc;
    endtask

    task automatic retire_trap();
        stim_t s;
        s       = make_stim(INSN_ECALL, 4'd0);
        s.exc   = 1'b1;
        s.intr  = 1'($urandom % 2);
        s.cause = 5'($urandom);
        s.tval  = $urandom;
        drive_cycle(s);
        // jump to a handler
        cur_pc = 32'h0000_0100 + 32'(4 * ($urandom % 64));
    endtask

    initial begin
        int unsigned r;
        void'($urandom(SEED));
        clk         = 1'b0;
        reset       = 1'b1;
        iretired    = 1'b0;
        exception   = 1'b0;
        interrupt   = 1'b0;
        cause       = '0;
        tval        = '0;
        priv_lvl    = '0;
        inst_data   = '0;
        pc          = '0;
        trigger     = '0;
        trace_on    = 1'b0;
        nc          = '0;
        tc          = '0;
        lc          = '0;
        map_cnt     = '0;
        map_bits    = '0;
        sync_cnt    = 0;
        cur_pc      = 32'h8000_0000;
        cur_priv    = 2'd3;
        cycle_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // retirements without trace-on give nothing
        repeat (IDLE_CYCLES) retire_seq(4'd0);

        // start on the first pc, stop after a short run
        retire_seq(4'd2);
        repeat (10) retire_seq(4'd0);
        retire_seq(4'd3);
        repeat (4) idle_cycle(4'd0);

        // traps with handler pc in the next retirement
        idle_cycle(4'd2);
        repeat (6) begin
            repeat (1 + $urandom % 4) retire_seq(4'd0);
            retire_trap();
            retire_seq(4'd0);
            retire_seq(4'd0);
        end
        idle_cycle(4'd3);

        // branch runs closed by an uninferable jump, then one past a full map
        idle_cycle(4'd2);
        repeat (4) begin
            repeat (3 + $urandom % 20) retire_branch(1'($urandom % 2));
            retire_jump();
            retire_seq(4'd0);
        end
        repeat (40) retire_branch(1'($urandom % 2));
        retire_jump();

        // straight-line code long enough for a resync
        repeat (RESYNC_CYCLES) retire_seq(4'd0);

        // mixed stream
        repeat (RANDOM_CYCLES) begin
            r = $urandom % 100;
            if ($urandom % 50 == 0) begin
                cur_priv = 2'($urandom);
            end
            if (r < 10) begin
                idle_cycle(4'd0);
            end else if (r < 40) begin
                retire_branch(1'($urandom % 2));
            end else if (r < 48) begin
                retire_jump();
            end else if (r < 53) begin
                retire_trap();
            end else if (r < 55) begin
                retire_seq(4'd3);
            end else if (r < 58) begin
                retire_seq(4'd2);
            end else begin
                retire_seq(4'd0);
            end
        end

        // let the last packets leave the pipe
        repeat (DRAIN_CYCLES) idle_cycle(4'd3);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* flist.f */
trdb_cpu_pkg.sv
trdb_pkg.sv
trdb_trigger_filter.sv
trdb_stage_pipe.sv
trdb_branch_map.sv
trdb_packet_emitter.sv
trace_debugger.sv
trdb_checker.sv
trdb_tb.sv

/* run.sh */
#!/bin/sh
# build and run the trace encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module trdb_tb -f flist.f -o trdb_sim

status=0
./obj_dir/trdb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
